//--- common/isa_pkg.sv
// instruction set encodings for the scalar and matrix front end
// import where an instruction word has to be decoded
package isa_pkg;

    // major opcodes, matrix ops sit in the custom opcode space
    typedef enum logic [6:0] {
        RTYPE    = 7'b0110011,
        ITYPE    = 7'b0010011,
        ITYPE_LW = 7'b0000011,
        STYPE    = 7'b0100011,
        BTYPE    = 7'b1100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        LUI      = 7'b0110111,
        HALT     = 7'b1111111,
        LD_M     = 7'b0001011,
        ST_M     = 7'b0101011,
        GEMM     = 7'b1011011
    } opcode_t;

    typedef enum logic [2:0] {
        ADD_SUB = 3'h0,
        SLL     = 3'h1,
        SLT     = 3'h2,
        SLTU    = 3'h3,
        XOR     = 3'h4,
        SRL_SRA = 3'h5,
        OR      = 3'h6,
        AND     = 3'h7
    } funct3_r_t;

    typedef enum logic [2:0] {
        ADDI      = 3'h0,
        SLLI      = 3'h1,
        SLTI      = 3'h2,
        SLTIU     = 3'h3,
        XORI      = 3'h4,
        SRLI_SRAI = 3'h5,
        ORI       = 3'h6,
        ANDI      = 3'h7
    } funct3_i_t;

    typedef enum logic [2:0] {
        BEQ  = 3'h0,
        BNE  = 3'h1,
        BLT  = 3'h4,
        BGE  = 3'h5,
        BLTU = 3'h6,
        BGEU = 3'h7
    } funct3_b_t;

    // one word, several views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            funct3_r_t  funct3;
            logic [4:0] rd;
            opcode_t    opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            funct3_i_t   funct3;
            logic [4:0]  rd;
            opcode_t     opcode;
        } i;
        // stores and branches share this layout
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            funct3_b_t  funct3;
            logic [4:0] imm_lo;
            opcode_t    opcode;
        } s;
        // lui and jal
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            opcode_t     opcode;
        } u;
        struct packed {
            logic [3:0] mrd;
            logic [4:0] rs1;
            logic [4:0] stride;
            logic       off_sign;
            logic [9:0] offset;
            opcode_t    opcode;
        } m;
    } instr_u;

endpackage

//--- common/datapath_pkg.sv
// decoded control types and the bundle handed to the back end
// import in any block that carries decoded instructions
package datapath_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } aluop_t;

    typedef enum logic [2:0] {
        BT_NONE,
        BT_BEQ,
        BT_BNE,
        BT_BLT,
        BT_BGE,
        BT_BLTU,
        BT_BGEU
    } branch_t;

    typedef enum logic [1:0] {SM_NONE, LOAD, STORE} scalar_mem_t;

    typedef enum logic [1:0] {MM_NONE, M_LOAD, M_STORE} matrix_mem_t;

    typedef enum logic {UT_NONE, UT_LOAD} utype_t;

    typedef enum logic [1:0] {FU_NONE, FU_S_ALU, FU_S_LD_ST, FU_S_BRANCH} fu_scalar_t;

    typedef enum logic [1:0] {FU_M_NONE, FU_M_LD_ST, FU_M_GEMM} fu_matrix_t;

    // scalar, matrix load/store or gemm side
    typedef enum logic [1:0] {FU_S_T, FU_M_T, FU_G_T} fu_type_t;

    // one issued instruction, 96 bits
    typedef struct packed {
        word_t       pc;
        word_t       imm;
        logic [4:0]  stride;
        logic [3:0]  matrix_rd;
        aluop_t      alu_op;
        branch_t     branch_op;
        scalar_mem_t s_mem_type;
        matrix_mem_t m_mem_type;
        utype_t      u_type;
        fu_scalar_t  fu_s;
        fu_matrix_t  fu_m;
        fu_type_t    fu_t;
        logic        i_flag;
        logic        s_reg_write;
        logic        m_reg_write;
        logic        jal;
        logic        jalr;
    } issue_t;

endpackage

//--- common/fetch_if.sv
// buffered instruction word and its pc, from fetch to decode and dispatch
`timescale 1ns/1ps

interface fetch_if import datapath_pkg::*; ();

    logic  valid;
    word_t instr;
    word_t pc;
    // dispatch empties the buffer at the next edge
    logic  take;

    modport fetch (output valid, instr, pc, input take);

    modport decode (input instr);

    modport dispatch (input valid, pc, output take);

endinterface

//--- common/control_unit_if.sv
// decoded control fields, control unit to dispatch
`timescale 1ns/1ps

interface control_unit_if import datapath_pkg::*; ();

    logic        halt;
    logic        i_flag;
    logic        s_reg_write;
    logic        m_reg_write;
    logic        jal;
    logic        jalr;
    utype_t      u_type;
    aluop_t      alu_op;
    branch_t     branch_op;
    word_t       imm;
    logic [4:0]  stride;
    fu_scalar_t  fu_s;
    fu_matrix_t  fu_m;
    fu_type_t    fu_t;
    scalar_mem_t s_mem_type;
    matrix_mem_t m_mem_type;
    logic [3:0]  matrix_rd;

    modport cu (
        output halt, i_flag, s_reg_write, m_reg_write, jal, jalr, u_type, alu_op,
               branch_op, imm, stride, fu_s, fu_m, fu_t, s_mem_type, m_mem_type, matrix_rd
    );

    modport dispatch (
        input halt, i_flag, s_reg_write, m_reg_write, jal, jalr, u_type, alu_op,
              branch_op, imm, stride, fu_s, fu_m, fu_t, s_mem_type, m_mem_type, matrix_rd
    );

endinterface

//--- control_unit/control_unit.sv
// combinational decoder, one instruction word into control fields
// unknown opcodes leave every control inactive
`timescale 1ns/1ps

module control_unit import isa_pkg::*; import datapath_pkg::*; (
    fetch_if.decode     fif,
    control_unit_if.cu  cu
);

    instr_u w;
    word_t  imm_i;
    word_t  imm_s;
    word_t  imm_b;
    word_t  imm_j;
    word_t  imm_u;
    word_t  imm_m;
    logic   alt;

    assign w = fif.instr;

    // funct7 0x20 picks sub / sra
    assign alt = (w.r.funct7 == 7'h20);

    assign imm_i = {{20{w.i.imm12[11]}}, w.i.imm12};
    assign imm_s = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
    assign imm_b = {{19{w.s.imm_hi[6]}}, w.s.imm_hi[6], w.s.imm_lo[0],
                    w.s.imm_hi[5:0], w.s.imm_lo[4:1], 1'b0};
    assign imm_j = {{11{w.u.imm20[19]}}, w.u.imm20[19], w.u.imm20[7:0],
                    w.u.imm20[8], w.u.imm20[18:9], 1'b0};
    assign imm_u = {w.u.imm20, 12'b0};
    // matrix offset, sign sits at bit 17
    assign imm_m = {{22{w.m.off_sign}}, w.m.offset};

    always_comb
    begin
        cu.halt        = 1'b0;
        cu.i_flag      = 1'b0;
        cu.s_reg_write = 1'b0;
        cu.m_reg_write = 1'b0;
        cu.jal         = 1'b0;
        cu.jalr        = 1'b0;
        cu.u_type      = UT_NONE;
        cu.alu_op      = ALU_ADD;
        cu.branch_op   = BT_NONE;
        cu.imm         = '0;
        cu.stride      = '0;
        cu.fu_s        = FU_NONE;
        cu.fu_m        = FU_M_NONE;
        cu.fu_t        = FU_S_T;
        cu.s_mem_type  = SM_NONE;
        cu.m_mem_type  = MM_NONE;
        cu.matrix_rd   = '0;
        case (w.r.opcode)
            RTYPE:
            begin
                cu.s_reg_write = 1'b1;
                cu.fu_s        = FU_S_ALU;
                case (w.r.funct3)
                    ADD_SUB: cu.alu_op = alt ? ALU_SUB : ALU_ADD;
                    SLL:     cu.alu_op = ALU_SLL;
                    SLT:     cu.alu_op = ALU_SLT;
                    SLTU:    cu.alu_op = ALU_SLTU;
                    XOR:     cu.alu_op = ALU_XOR;
                    SRL_SRA: cu.alu_op = alt ? ALU_SRA : ALU_SRL;
                    OR:      cu.alu_op = ALU_OR;
                    AND:     cu.alu_op = ALU_AND;
                    default: cu.alu_op = ALU_ADD;
                endcase
            end
            ITYPE:
            begin
                cu.s_reg_write = 1'b1;
                cu.i_flag      = 1'b1;
                cu.imm         = imm_i;
                cu.fu_s        = FU_S_ALU;
                case (w.i.funct3)
                    ADDI:      cu.alu_op = ALU_ADD;
                    SLLI:      cu.alu_op = ALU_SLL;
                    SLTI:      cu.alu_op = ALU_SLT;
                    SLTIU:     cu.alu_op = ALU_SLTU;
                    XORI:      cu.alu_op = ALU_XOR;
                    SRLI_SRAI: cu.alu_op = alt ? ALU_SRA : ALU_SRL;
                    ORI:       cu.alu_op = ALU_OR;
                    ANDI:      cu.alu_op = ALU_AND;
                    default:   cu.alu_op = ALU_ADD;
                endcase
            end
            // only word accesses are supported
            ITYPE_LW:
            begin
                if (w.i.funct3 == 3'h2)
                begin
                    cu.s_reg_write = 1'b1;
                    cu.i_flag      = 1'b1;
                    cu.imm         = imm_i;
                    cu.s_mem_type  = LOAD;
                    cu.fu_s        = FU_S_LD_ST;
                end
            end
            STYPE:
            begin
                if (w.s.funct3 == 3'h2)
                begin
                    cu.imm        = imm_s;
                    cu.s_mem_type = STORE;
                    cu.fu_s       = FU_S_LD_ST;
                end
            end
            BTYPE:
            begin
                cu.imm  = imm_b;
                cu.fu_s = FU_S_BRANCH;
                case (w.s.funct3)
                    BEQ:     cu.branch_op = BT_BEQ;
                    BNE:     cu.branch_op = BT_BNE;
                    BLT:     cu.branch_op = BT_BLT;
                    BGE:     cu.branch_op = BT_BGE;
                    BLTU:    cu.branch_op = BT_BLTU;
                    BGEU:    cu.branch_op = BT_BGEU;
                    default: cu.branch_op = BT_NONE;
                endcase
            end
            JAL:
            begin
                cu.jal         = 1'b1;
                cu.s_reg_write = 1'b1;
                cu.i_flag      = 1'b1;
                cu.imm         = imm_j;
                cu.fu_s        = FU_S_BRANCH;
            end
            JALR:
            begin
                cu.jalr        = 1'b1;
                cu.s_reg_write = 1'b1;
                cu.i_flag      = 1'b1;
                cu.imm         = imm_i;
                cu.fu_s        = FU_S_BRANCH;
            end
            LUI:
            begin
                cu.u_type      = UT_LOAD;
                cu.s_reg_write = 1'b1;
                cu.i_flag      = 1'b1;
                cu.imm         = imm_u;
                cu.fu_s        = FU_S_ALU;
            end
            HALT: cu.halt = 1'b1;
            LD_M, ST_M:
            begin
                cu.imm         = imm_m;
                cu.stride      = w.m.stride;
                cu.matrix_rd   = w.m.mrd;
                cu.fu_m        = FU_M_LD_ST;
                cu.fu_t        = FU_M_T;
                // st.m writes memory, not a matrix register
                cu.m_reg_write = (w.m.opcode == LD_M);
                cu.m_mem_type  = (w.m.opcode == LD_M) ? M_LOAD : M_STORE;
            end
            GEMM:
            begin
                cu.fu_m        = FU_M_GEMM;
                cu.fu_t        = FU_G_T;
                cu.m_reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- source/instr_fetch.sv
// sequential instruction fetch, Wishbone classic read master
// one word is buffered and a new read starts once it has been taken
`timescale 1ns/1ps

module instr_fetch import datapath_pkg::*; #(
    parameter word_t RESET_PC   = 32'h0000_0000,
    parameter int    ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [ADDR_WIDTH-1:0] wb_adr,
    input  word_t                 wb_dat_i,
    input  logic                  wb_ack,
    fetch_if.fetch                fif
);

    word_t pc_q;
    logic  cyc_q;
    logic  buf_valid;
    word_t buf_instr;
    word_t buf_pc;

    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;
    assign wb_we  = 1'b0;
    assign wb_adr = pc_q[ADDR_WIDTH-1:0];

    assign fif.valid = buf_valid;
    assign fif.instr = buf_instr;
    assign fif.pc    = buf_pc;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc_q      <= RESET_PC;
            cyc_q     <= 1'b0;
            buf_valid <= 1'b0;
        end
        else
        begin
            // bus cycle ends on ack, word lands in the buffer
            if (cyc_q && wb_ack)
            begin
                cyc_q     <= 1'b0;
                buf_valid <= 1'b1;
                pc_q      <= pc_q + 32'd4;
            end
            else if (!cyc_q && !buf_valid)
                cyc_q <= 1'b1;
            else if (fif.take)
                buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cyc_q && wb_ack)
        begin
            buf_instr <= wb_dat_i;
            buf_pc    <= pc_q;
        end
    end

    a_stb_hold: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> wb_stb);

    // a full buffer that dispatch has not taken must not be overwritten
    a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        (fif.valid && !fif.take) |-> !(wb_cyc && wb_ack));

endmodule

//--- source/dispatch_stage.sv
// issue register between decode and the back end, valid/ready handshake
// a halt word is consumed here and stops any further take
`timescale 1ns/1ps

module dispatch_stage import datapath_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue_ready,
    fetch_if.dispatch        fif,
    control_unit_if.dispatch cu,
    output logic             issue_valid,
    output issue_t           issue_bundle,
    output logic             halted
);

    issue_t next_bundle;
    logic   out_valid;
    logic   take;

    // register free, or emptied at this edge
    assign take     = fif.valid && (!out_valid || issue_ready) && !halted;
    // a halt word stays in the buffer, so fetch never starts another read
    assign fif.take = take && !cu.halt;

    always_comb
    begin
        next_bundle.pc          = fif.pc;
        next_bundle.imm         = cu.imm;
        next_bundle.stride      = cu.stride;
        next_bundle.matrix_rd   = cu.matrix_rd;
        next_bundle.alu_op      = cu.alu_op;
        next_bundle.branch_op   = cu.branch_op;
        next_bundle.s_mem_type  = cu.s_mem_type;
        next_bundle.m_mem_type  = cu.m_mem_type;
        next_bundle.u_type      = cu.u_type;
        next_bundle.fu_s        = cu.fu_s;
        next_bundle.fu_m        = cu.fu_m;
        next_bundle.fu_t        = cu.fu_t;
        next_bundle.i_flag      = cu.i_flag;
        next_bundle.s_reg_write = cu.s_reg_write;
        next_bundle.m_reg_write = cu.m_reg_write;
        next_bundle.jal         = cu.jal;
        next_bundle.jalr        = cu.jalr;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end
        else
        begin
            if (take && !cu.halt)
                out_valid <= 1'b1;
            else if (issue_ready)
                out_valid <= 1'b0;
            if (take && cu.halt)
                halted <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take && !cu.halt)
            issue_bundle <= next_bundle;
    end

    assign issue_valid = out_valid;

    a_stall_stable: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_bundle)));

endmodule

//--- source/decode_top.sv
// fetch and decode front end, Wishbone fetch port and issue stream
// set RESET_PC and ADDR_WIDTH here, they reach the fetch unit
`timescale 1ns/1ps

module decode_top import datapath_pkg::*; #(
    parameter word_t RESET_PC   = 32'h0000_0000,
    parameter int    ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [ADDR_WIDTH-1:0] wb_adr,
    input  word_t                 wb_dat_i,
    input  logic                  wb_ack,
    output logic                  issue_valid,
    input  logic                  issue_ready,
    output issue_t                issue_bundle,
    output logic                  halted
);

    fetch_if        fif ();
    control_unit_if cuif ();

    instr_fetch #(
        .RESET_PC   (RESET_PC),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_fetch (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .fif      (fif.fetch)
    );

    control_unit u_cu (
        .fif (fif.decode),
        .cu  (cuif.cu)
    );

    dispatch_stage u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .issue_ready  (issue_ready),
        .fif          (fif.dispatch),
        .cu           (cuif.dispatch),
        .issue_valid  (issue_valid),
        .issue_bundle (issue_bundle),
        .halted       (halted)
    );

endmodule

//--- verification/tb_program.svh
// test program and the expected issue table, included by the testbench
// the table rows follow the instruction set rules, one row per issued word
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN  = 25;
localparam int NUM_ISSUE = 22;

logic [31:0] prog [PROG_LEN];
issue_t      exp_tab [NUM_ISSUE];

function automatic logic [31:0] enc_r(logic [31:0] f7, rs2, rs1, f3, rd, op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_i(logic [31:0] imm, rs1, f3, rd, op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_s(logic [31:0] imm, rs2, rs1, f3, op);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_b(logic [31:0] imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(logic [31:0] imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

// matrix word, offset is 11-bit two's complement in 17:7
function automatic logic [31:0] enc_m(logic [31:0] mrd, rs1, stride, off, op);
    return {mrd[3:0], rs1[4:0], stride[4:0], off[10:0], op[6:0]};
endfunction

function automatic issue_t blank_row(int k);
    issue_t r;
    r     = '0;
    r.pc  = RESET_PC + 32'(4 * k);
    r.fu_t = FU_S_T;
    r.fu_s = FU_NONE;
    return r;
endfunction

task automatic alu_row(int k, logic [31:0] word, aluop_t op, logic imm_f, logic [31:0] imm);
    prog[k] = word;
    exp_tab[k] = blank_row(k);
    exp_tab[k].alu_op = op;
    exp_tab[k].s_reg_write = 1'b1;
    exp_tab[k].i_flag = imm_f;
    exp_tab[k].imm = imm;
    exp_tab[k].fu_s = FU_S_ALU;
endtask

task automatic branch_row(int k, logic [31:0] f3, branch_t op, logic [31:0] imm);
    prog[k] = enc_b(imm, 4, 3, f3);
    exp_tab[k] = blank_row(k);
    exp_tab[k].branch_op = op;
    exp_tab[k].imm = imm;
    exp_tab[k].fu_s = FU_S_BRANCH;
endtask

task automatic fill_table();
    alu_row(0, enc_r(0, 3, 2, 0, 1, 7'h33), ALU_ADD, 1'b0, 0);
    alu_row(1, enc_r(7'h20, 3, 2, 0, 1, 7'h33), ALU_SUB, 1'b0, 0);
    alu_row(2, enc_r(7'h20, 5, 6, 5, 7, 7'h33), ALU_SRA, 1'b0, 0);
    alu_row(3, enc_r(0, 5, 6, 2, 7, 7'h33), ALU_SLT, 1'b0, 0);
    alu_row(4, enc_i(3, 1, 5, 2, 7'h13), ALU_SRL, 1'b1, 3);
    alu_row(5, enc_i(-16, 1, 7, 2, 7'h13), ALU_AND, 1'b1, -16);
    alu_row(6, enc_i(12'h407, 1, 5, 2, 7'h13), ALU_SRA, 1'b1, 32'h407);
    alu_row(7, enc_i(-4, 8, 2, 9, 7'h03), ALU_ADD, 1'b1, -4);
    exp_tab[7].s_mem_type = LOAD;
    exp_tab[7].fu_s = FU_S_LD_ST;
    prog[8] = enc_s(12, 9, 8, 2, 7'h23);
    exp_tab[8] = blank_row(8);
    exp_tab[8].imm = 12;
    exp_tab[8].s_mem_type = STORE;
    exp_tab[8].fu_s = FU_S_LD_ST;
    // byte load is not supported, nothing active
    prog[9] = enc_i(8, 8, 0, 9, 7'h03);
    exp_tab[9] = blank_row(9);
    branch_row(10, 0, BT_BEQ, -8);
    branch_row(11, 1, BT_BNE, 16);
    branch_row(12, 4, BT_BLT, 2048);
    branch_row(13, 5, BT_BGE, -4096);
    branch_row(14, 6, BT_BLTU, 4);
    branch_row(15, 7, BT_BGEU, 100);
    alu_row(16, enc_j(-1024, 1), ALU_ADD, 1'b1, -1024);
    exp_tab[16].jal = 1'b1;
    exp_tab[16].fu_s = FU_S_BRANCH;
    alu_row(17, enc_i(20, 5, 0, 1, 7'h67), ALU_ADD, 1'b1, 20);
    exp_tab[17].jalr = 1'b1;
    exp_tab[17].fu_s = FU_S_BRANCH;
    alu_row(18, {20'hABCDE, 5'd3, 7'h37}, ALU_ADD, 1'b1, 32'hABCDE000);
    exp_tab[18].u_type = UT_LOAD;
    prog[19] = enc_m(5, 2, 3, -5, 7'h0b);
    exp_tab[19] = blank_row(19);
    exp_tab[19].imm = -5;
    exp_tab[19].stride = 3;
    exp_tab[19].matrix_rd = 5;
    exp_tab[19].fu_m = FU_M_LD_ST;
    exp_tab[19].fu_t = FU_M_T;
    exp_tab[19].m_reg_write = 1'b1;
    exp_tab[19].m_mem_type = M_LOAD;
    prog[20] = enc_m(9, 4, 7, 300, 7'h2b);
    exp_tab[20] = blank_row(20);
    exp_tab[20].imm = 300;
    exp_tab[20].stride = 7;
    exp_tab[20].matrix_rd = 9;
    exp_tab[20].fu_m = FU_M_LD_ST;
    exp_tab[20].fu_t = FU_M_T;
    exp_tab[20].m_mem_type = M_STORE;
    prog[21] = enc_m(2, 1, 1, 0, 7'h5b);
    exp_tab[21] = blank_row(21);
    exp_tab[21].fu_m = FU_M_GEMM;
    exp_tab[21].fu_t = FU_G_T;
    exp_tab[21].m_reg_write = 1'b1;
    prog[22] = 32'h0000_007f;
    // words past halt must never be fetched
    prog[23] = enc_r(0, 3, 2, 0, 1, 7'h33);
    prog[24] = enc_r(0, 3, 2, 0, 1, 7'h33);
endtask

`endif

//--- verification/tb_decode_top.sv
// testbench for the decode front end, Wishbone memory model and issue sink
// random wait states and back-pressure, checks done by assertions
`timescale 1ns/1ps

module tb_decode_top import datapath_pkg::*; ();

    localparam word_t RESET_PC = 32'h0000_0100;
    localparam int    CLK_NS   = 20;
    localparam int    LIMIT_NS = 25 * 8 * CLK_NS + 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    word_t       wb_dat_i;
    logic        wb_ack;
    logic        issue_valid;
    logic        issue_ready;
    issue_t      issue_bundle;
    logic        halted;

    int          errors = 0;
    int          exp_idx = 0;
    logic [15:0] lfsr = 16'd57103;
    int          wait_left = 0;
    logic        pending = 1'b0;
    logic        seen_edge = 1'b0;
    logic        first_fetch = 1'b1;

    `include "tb_program.svh"

    decode_top #(
        .RESET_PC   (RESET_PC),
        .ADDR_WIDTH (32)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_bundle (issue_bundle),
        .halted       (halted)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // galois lfsr, one step per bit
    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int b = 0; b < n; b++)
        begin
            val = (val << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic word_t mem_word(logic [31:0] adr);
        int idx;
        idx = int'((adr - RESET_PC) >> 2);
        if (idx >= 0 && idx < PROG_LEN)
            return prog[idx];
        return 32'h0;
    endfunction

    task automatic check_field(string name, logic [31:0] exp, logic [31:0] got);
        if (exp !== got)
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic report_mismatch(issue_t exp, issue_t got);
        errors++;
        check_field("pc", exp.pc, got.pc);
        check_field("imm", exp.imm, got.imm);
        check_field("stride", 32'(exp.stride), 32'(got.stride));
        check_field("matrix_rd", 32'(exp.matrix_rd), 32'(got.matrix_rd));
        check_field("alu_op", 32'(exp.alu_op), 32'(got.alu_op));
        check_field("branch_op", 32'(exp.branch_op), 32'(got.branch_op));
        check_field("s_mem_type", 32'(exp.s_mem_type), 32'(got.s_mem_type));
        check_field("m_mem_type", 32'(exp.m_mem_type), 32'(got.m_mem_type));
        check_field("u_type", 32'(exp.u_type), 32'(got.u_type));
        check_field("fu_s", 32'(exp.fu_s), 32'(got.fu_s));
        check_field("fu_m", 32'(exp.fu_m), 32'(got.fu_m));
        check_field("fu_t", 32'(exp.fu_t), 32'(got.fu_t));
        check_field("i_flag", 32'(exp.i_flag), 32'(got.i_flag));
        check_field("s_reg_write", 32'(exp.s_reg_write), 32'(got.s_reg_write));
        check_field("m_reg_write", 32'(exp.m_reg_write), 32'(got.m_reg_write));
        check_field("jal", 32'(exp.jal), 32'(got.jal));
        check_field("jalr", 32'(exp.jalr), 32'(got.jalr));
    endtask

    // memory model, ack after 0 to 3 extra cycles
    always @(negedge clk)
    begin
        int r;
        if (reset)
        begin
            wb_ack  = 1'b0;
            pending = 1'b0;
        end
        else if (wb_stb && !wb_ack)
        begin
            if (!pending)
            begin
                pending = 1'b1;
                wait_left = rand_bits(2);
            end
            if (wait_left == 0)
            begin
                wb_ack   = 1'b1;
                wb_dat_i = mem_word(wb_adr);
                pending  = 1'b0;
            end
            else
                wait_left--;
        end
        else
            wb_ack = 1'b0;
        // sink ready three times in four
        r = rand_bits(2);
        issue_ready = (r != 0);
    end

    always @(posedge clk)
    begin
        seen_edge <= 1'b1;
        if (!reset && wb_stb)
            first_fetch <= 1'b0;
        if (!reset && issue_valid && issue_ready)
            exp_idx <= exp_idx + 1;
    end

    a_bundle: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && issue_ready && exp_idx < NUM_ISSUE) |->
            issue_bundle == exp_tab[exp_idx])
        else report_mismatch(exp_tab[$sampled(exp_idx)], $sampled(issue_bundle));

    a_no_extra: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && issue_ready) |-> exp_idx < NUM_ISSUE)
        else
        begin
            errors++;
            $display("more instructions were issued than the program holds before halt");
        end

    a_stable: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_bundle)))
        else
        begin
            errors++;
            $display("issue bundle changed or dropped while the sink was stalled");
        end

    a_reset_state: assert property (@(posedge clk)
        (reset && seen_edge) |-> (!wb_cyc && !wb_stb && !issue_valid && !halted))
        else
        begin
            errors++;
            $display("an output was active during reset");
        end

    a_first_adr: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && first_fetch) |-> wb_adr == RESET_PC)
        else
        begin
            errors++;
            $display("[FAIL] %0t wb_adr expected %h got %h", $time, RESET_PC,
                     $sampled(wb_adr));
        end

    // fetch only ever reads
    a_read_only: assert property (@(posedge clk) disable iff (reset) !wb_we)
        else
        begin
            errors++;
            $display("[FAIL] %0t wb_we expected 0 got %b", $time, $sampled(wb_we));
        end

    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |-> !wb_cyc)
        else
        begin
            errors++;
            $display("a bus cycle started after halt");
        end

    a_halt_count: assert property (@(posedge clk) disable iff (reset)
        $rose(halted) |-> (exp_idx == NUM_ISSUE && !issue_valid))
        else
        begin
            errors++;
            $display("halted rose before every word ahead of halt was issued");
        end

    initial
    begin
        #(LIMIT_NS);
        $display("watchdog expired before the program halted");
        $display("Errors found");
        $finish;
    end

    initial
    begin
        reset       = 1'b1;
        wb_ack      = 1'b0;
        wb_dat_i    = '0;
        issue_ready = 1'b0;
        fill_table();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        wait (halted);
        // let the front end sit idle to see that nothing more happens
        repeat (30) @(negedge clk);
        if (exp_idx != NUM_ISSUE)
        begin
            errors++;
            $display("issued %0d instructions instead of %0d", exp_idx, NUM_ISSUE);
        end
        $display("checks finished, %0d errors", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- flist.f
common/isa_pkg.sv
common/datapath_pkg.sv
common/fetch_if.sv
common/control_unit_if.sv
control_unit/control_unit.sv
source/instr_fetch.sv
source/dispatch_stage.sv
source/decode_top.sv
+incdir+verification
verification/tb_decode_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_decode_top
FLIST    = flist.f
PASS_MSG = No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
